/* obstacle_map.f */
+incdir+verilog
verilog/map_geom_pkg.sv
verilog/game_ctrl_pkg.sv
verilog/obstacle_shape_gen.sv
verilog/obstacle_field.sv
verilog/screen_bounds.sv
verilog/obstacle_map.sv
dv/obstacle_map_checker.sv
dv/obstacle_map_tb.sv

/* dv/obstacle_map_tb.sv */
`timescale 1ns/1ns

`include "obstacle_map_macros.svh"

module obstacle_map_tb;
    import map_geom_pkg::*;
    import game_ctrl_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 4;
    localparam int IDLE_CYCLES   = 8;
    localparam int PAUSE_CYCLES  = 50;
    localparam int REPLAY_CYCLES = 300;
    localparam int FLUSH_CYCLES  = 4;
    localparam int SLACK_CYCLES  = 200;

    logic                           clk;
    logic                           rst_n;
    game_mode_t                     game_mode;
    score_t                         score;
    screen_x_t [`NUM_OBSTACLES-1:0] obstacle_x_left;
    screen_x_t [`NUM_OBSTACLES-1:0] obstacle_x_right;
    screen_y_t [`NUM_OBSTACLES-1:0] obstacle_y_up;
    screen_y_t [`NUM_OBSTACLES-1:0] obstacle_y_down;
    logic                           report;
    int                             error_count;
    int                             play_cycles;
    int                             limit_cycles;
    int unsigned                    seed;

    always #(CLK_PERIOD / 2) clk = ~clk;

    obstacle_map dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .game_mode        (game_mode),
        .score            (score),
        .obstacle_x_left  (obstacle_x_left),
        .obstacle_x_right (obstacle_x_right),
        .obstacle_y_up    (obstacle_y_up),
        .obstacle_y_down  (obstacle_y_down)
    );

    obstacle_map_checker u_checker (
        .clk              (clk),
        .rst_n            (rst_n),
        .game_mode        (game_mode),
        .score            (score),
        .obstacle_x_left  (obstacle_x_left),
        .obstacle_x_right (obstacle_x_right),
        .obstacle_y_up    (obstacle_y_up),
        .obstacle_y_down  (obstacle_y_down),
        .report           (report),
        .error_count      (error_count)
    );

    // Called right after a rising edge
    task automatic hold_mode(input game_mode_t mode, input int cycles);
        game_mode <= mode;
        repeat (cycles) @(posedge clk);
    endtask

    // ========================================================
    // Mode sequence
    // ========================================================
    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        game_mode    = MODE_IDLE;
        report       = 1'b0;
        seed         = 68389;
        play_cycles  = 1500 + ($urandom(seed) % 1001);
        limit_cycles = RESET_CYCLES + 2 * IDLE_CYCLES + play_cycles + PAUSE_CYCLES
                       + REPLAY_CYCLES + FLUSH_CYCLES + SLACK_CYCLES;
        $display("First play phase lasts %0d cycles", play_cycles);
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        hold_mode(MODE_IDLE, IDLE_CYCLES);
        hold_mode(MODE_PLAY, play_cycles);
        hold_mode(MODE_PAUSE, PAUSE_CYCLES);
        hold_mode(MODE_IDLE, IDLE_CYCLES);
        hold_mode(MODE_PLAY, REPLAY_CYCLES);
        repeat (FLUSH_CYCLES) @(posedge clk);
        report <= 1'b1;
        @(posedge clk);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the run never reached its end", limit_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* dv/obstacle_map_checker.sv */
`timescale 1ns/1ns

`include "obstacle_map_macros.svh"

module obstacle_map_checker (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  game_ctrl_pkg::game_mode_t                    game_mode,
    input  game_ctrl_pkg::score_t                        score,
    input  map_geom_pkg::screen_x_t [`NUM_OBSTACLES-1:0] obstacle_x_left,
    input  map_geom_pkg::screen_x_t [`NUM_OBSTACLES-1:0] obstacle_x_right,
    input  map_geom_pkg::screen_y_t [`NUM_OBSTACLES-1:0] obstacle_y_up,
    input  map_geom_pkg::screen_y_t [`NUM_OBSTACLES-1:0] obstacle_y_down,
    input  logic                                         report,
    output int                                           error_count
);
    import map_geom_pkg::*;
    import game_ctrl_pkg::*;

    localparam int NUM_TESTS   = 5;
    localparam int FIRST_LEFT  = `SCREEN_WIDTH - `SCROLL_SPEED;
    localparam int MIN_SPACING = `MIN_GAP / `SCROLL_SPEED;
    localparam int MAX_SPACING = `MAX_GAP / `SCROLL_SPEED + 1;

    // Tests: reset/idle, shape ranges, scrolling, spawn spacing, score
    int    checks [NUM_TESTS];
    int    errors [NUM_TESTS];
    string names  [NUM_TESTS];

    // Shadow of every obstacle seen on screen
    logic  m_active [`NUM_OBSTACLES];
    int    m_x      [`NUM_OBSTACLES];
    int    m_w      [`NUM_OBSTACLES];
    int    ref_score;

    game_mode_t mode_e;
    game_mode_t mode_e1;
    int         last_score;
    int         since_spawn;
    logic       have_spawn;
    int         total_err;
    int         failed_tests;
    screen_x_t [`NUM_OBSTACLES-1:0] last_left;
    screen_x_t [`NUM_OBSTACLES-1:0] last_right;
    screen_y_t [`NUM_OBSTACLES-1:0] last_up;
    screen_y_t [`NUM_OBSTACLES-1:0] last_down;

    function automatic string sig_name(input string base, input int i);
        return $sformatf("%s[%0d]", base, i);
    endfunction

    function automatic logic is_pause(input game_mode_t m);
        return (m != MODE_IDLE) && (m != MODE_PLAY);
    endfunction

    // Reference model of one play cycle, returns the expected score
    function automatic int play_step(input int prev_score);
        int n;
        n = 0;
        for (int i = 0; i < `NUM_OBSTACLES; i++) begin
            if (m_active[i]) begin
                if (m_x[i] + m_w[i] < `DELETE_BOUNDARY) begin
                    m_active[i] = 1'b0;
                    n++;
                end else begin
                    m_x[i] = m_x[i] - `SCROLL_SPEED;
                end
            end
        end
        return (prev_score + n > `SCORE_MAX) ? `SCORE_MAX : prev_score + n;
    endfunction

    task automatic expect_eq(input int t, input string sig, input int exp, input int act);
        checks[t] = checks[t] + 1;
        if (exp != act) begin
            errors[t] = errors[t] + 1;
            $display("FAIL time=%0t signal=%s expected=%0d actual=%0d", $time, sig, exp, act);
        end
    endtask

    task automatic within_range(input int t, input string sig, input int lo, input int hi,
                                input int act);
        checks[t] = checks[t] + 1;
        if (act < lo || act > hi) begin
            errors[t] = errors[t] + 1;
            $display("FAIL time=%0t signal=%s expected=%0d..%0d actual=%0d",
                     $time, sig, lo, hi, act);
        end
    endtask

    task automatic note_error(input int t, input string what);
        errors[t] = errors[t] + 1;
        $display("ERROR time=%0t %s", $time, what);
    endtask

    task automatic verify_hidden();
        for (int i = 0; i < `NUM_OBSTACLES; i++) begin
            expect_eq(0, sig_name("obstacle_x_left", i), `HIDDEN_X, obstacle_x_left[i]);
            expect_eq(0, sig_name("obstacle_x_right", i), `HIDDEN_X, obstacle_x_right[i]);
            expect_eq(0, sig_name("obstacle_y_up", i), `HIDDEN_Y, obstacle_y_up[i]);
            expect_eq(0, sig_name("obstacle_y_down", i), `HIDDEN_Y, obstacle_y_down[i]);
        end
        expect_eq(0, "score", 0, score);
    endtask

    // ========================================================
    // Boxes against the shadow, new spawns and their spacing
    // ========================================================
    task automatic track_slots();
        logic spawned;
        spawned = 1'b0;
        for (int i = 0; i < `NUM_OBSTACLES; i++) begin
            if (obstacle_x_left[i] != `HIDDEN_X) begin
                within_range(1, sig_name("box_width", i), `MIN_OBSTACLE_WIDTH,
                             `MAX_OBSTACLE_WIDTH, obstacle_x_right[i] - obstacle_x_left[i]);
                within_range(1, sig_name("box_height", i), `MIN_OBSTACLE_HEIGHT,
                             `MAX_OBSTACLE_HEIGHT, obstacle_y_down[i] - obstacle_y_up[i]);
                within_range(1, sig_name("obstacle_y_up", i), `UPPER_BOUND, `LOWER_BOUND,
                             obstacle_y_up[i]);
                within_range(1, sig_name("obstacle_y_down", i), `UPPER_BOUND, `LOWER_BOUND,
                             obstacle_y_down[i]);
            end
            if (!m_active[i] && obstacle_x_left[i] != `HIDDEN_X) begin
                // Spawned at 640, first shown one step later
                expect_eq(2, sig_name("obstacle_x_left", i), FIRST_LEFT, obstacle_x_left[i]);
                m_active[i] = 1'b1;
                m_x[i]      = FIRST_LEFT;
                m_w[i]      = obstacle_x_right[i] - obstacle_x_left[i];
                spawned     = 1'b1;
            end else if (m_active[i] && m_x[i] >= 0 && m_x[i] < `SCREEN_WIDTH) begin
                expect_eq(2, sig_name("obstacle_x_left", i), m_x[i], obstacle_x_left[i]);
                expect_eq(2, sig_name("obstacle_x_right", i), m_x[i] + m_w[i],
                          obstacle_x_right[i]);
            end else if (m_active[i]) begin
                expect_eq(2, sig_name("obstacle_x_left", i), `HIDDEN_X, obstacle_x_left[i]);
            end
        end
        since_spawn = since_spawn + 1;
        if (spawned && have_spawn) begin
            within_range(3, "spawn_spacing", MIN_SPACING, MAX_SPACING, since_spawn);
        end
        if (spawned) begin
            since_spawn = 0;
            have_spawn  = 1'b1;
        end
        if (mode_e != MODE_PLAY) begin
            have_spawn = 1'b0;
        end
    endtask

    initial begin
        names[0] = "reset_idle";
        names[1] = "shape_ranges";
        names[2] = "scrolling";
        names[3] = "spawn_spacing";
        names[4] = "score";
        for (int t = 0; t < NUM_TESTS; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end
        error_count = 0;
        since_spawn = 0;
        have_spawn  = 1'b0;
    end

    // ========================================================
    // Sampled on the falling edge, away from DUT updates
    // ========================================================
    always @(negedge clk) begin
        if (!rst_n) begin
            verify_hidden();
            for (int i = 0; i < `NUM_OBSTACLES; i++) begin
                m_active[i] = 1'b0;
            end
            ref_score  = 0;
            mode_e     = MODE_IDLE;
            have_spawn = 1'b0;
        end else if (!report) begin
            // Outputs trail the field by one edge
            if (mode_e1 == MODE_IDLE) begin
                verify_hidden();
            end
            if (is_pause(mode_e1)) begin
                checks[2] = checks[2] + 1;
                if (obstacle_x_left != last_left || obstacle_x_right != last_right
                    || obstacle_y_up != last_up || obstacle_y_down != last_down) begin
                    note_error(2, "obstacle outputs changed while the game was paused");
                end
            end
            if (is_pause(mode_e)) begin
                expect_eq(2, "score", last_score, score);
            end
            if (mode_e == MODE_PLAY && score < last_score) begin
                note_error(4, "score went down during play");
            end
            track_slots();
            case (mode_e)
                MODE_IDLE: begin
                    for (int i = 0; i < `NUM_OBSTACLES; i++) begin
                        m_active[i] = 1'b0;
                    end
                    ref_score = 0;
                end
                MODE_PLAY: begin
                    ref_score = play_step(ref_score);
                end
                default: begin
                end
            endcase
            // Last edge of a pause
            if (is_pause(mode_e) && !is_pause(game_mode)) begin
                expect_eq(4, "score", ref_score, score);
            end
        end
        last_left  = obstacle_x_left;
        last_right = obstacle_x_right;
        last_up    = obstacle_y_up;
        last_down  = obstacle_y_down;
        last_score = score;
        mode_e1    = mode_e;
        mode_e     = game_mode;
    end

    always @(posedge report) begin
        total_err    = 0;
        failed_tests = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (checks[t] == 0) begin
                note_error(t, {names[t], " was never exercised"});
            end
            $display("%s: %0d checks, %0d errors, %s", names[t], checks[t], errors[t],
                     (errors[t] == 0) ? "passed" : "failed");
            total_err = total_err + errors[t];
            if (errors[t] != 0) begin
                failed_tests = failed_tests + 1;
            end
        end
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 NUM_TESTS, NUM_TESTS - failed_tests, failed_tests, total_err);
        error_count = total_err;
    end

endmodule

/* verilog/obstacle_map.sv */
`timescale 1ns/1ns

`include "obstacle_map_macros.svh"

module obstacle_map (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  game_ctrl_pkg::game_mode_t                    game_mode,
    output game_ctrl_pkg::score_t                        score,
    output map_geom_pkg::screen_x_t [`NUM_OBSTACLES-1:0] obstacle_x_left,
    output map_geom_pkg::screen_x_t [`NUM_OBSTACLES-1:0] obstacle_x_right,
    output map_geom_pkg::screen_y_t [`NUM_OBSTACLES-1:0] obstacle_y_up,
    output map_geom_pkg::screen_y_t [`NUM_OBSTACLES-1:0] obstacle_y_down
);
    import map_geom_pkg::*;

    // Generator to field offer
    logic        shape_valid;
    logic        shape_ready;
    obs_width_t  shape_width;
    obs_height_t shape_height;
    screen_y_t   shape_y;
    spawn_gap_t  shape_gap;

    // Field to display stage
    logic [`NUM_OBSTACLES-1:0]        slot_active;
    pos_x_t [`NUM_OBSTACLES-1:0]      slot_x;
    screen_y_t [`NUM_OBSTACLES-1:0]   slot_y;
    obs_width_t [`NUM_OBSTACLES-1:0]  slot_width;
    obs_height_t [`NUM_OBSTACLES-1:0] slot_height;

    obstacle_shape_gen u_shape_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .shape_ready  (shape_ready),
        .shape_valid  (shape_valid),
        .shape_width  (shape_width),
        .shape_height (shape_height),
        .shape_y      (shape_y),
        .shape_gap    (shape_gap)
    );

    obstacle_field u_field (
        .clk          (clk),
        .rst_n        (rst_n),
        .game_mode    (game_mode),
        .shape_valid  (shape_valid),
        .shape_width  (shape_width),
        .shape_height (shape_height),
        .shape_y      (shape_y),
        .shape_gap    (shape_gap),
        .shape_ready  (shape_ready),
        .slot_active  (slot_active),
        .slot_x       (slot_x),
        .slot_y       (slot_y),
        .slot_width   (slot_width),
        .slot_height  (slot_height),
        .score        (score)
    );

    screen_bounds u_bounds (
        .clk              (clk),
        .rst_n            (rst_n),
        .slot_active      (slot_active),
        .slot_x           (slot_x),
        .slot_y           (slot_y),
        .slot_width       (slot_width),
        .slot_height      (slot_height),
        .obstacle_x_left  (obstacle_x_left),
        .obstacle_x_right (obstacle_x_right),
        .obstacle_y_up    (obstacle_y_up),
        .obstacle_y_down  (obstacle_y_down)
    );

endmodule

/* verilog/screen_bounds.sv */
`timescale 1ns/1ns

`include "obstacle_map_macros.svh"

module screen_bounds (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic [`NUM_OBSTACLES-1:0]                      slot_active,
    input  map_geom_pkg::pos_x_t [`NUM_OBSTACLES-1:0]      slot_x,
    input  map_geom_pkg::screen_y_t [`NUM_OBSTACLES-1:0]   slot_y,
    input  map_geom_pkg::obs_width_t [`NUM_OBSTACLES-1:0]  slot_width,
    input  map_geom_pkg::obs_height_t [`NUM_OBSTACLES-1:0] slot_height,
    output map_geom_pkg::screen_x_t [`NUM_OBSTACLES-1:0]   obstacle_x_left,
    output map_geom_pkg::screen_x_t [`NUM_OBSTACLES-1:0]   obstacle_x_right,
    output map_geom_pkg::screen_y_t [`NUM_OBSTACLES-1:0]   obstacle_y_up,
    output map_geom_pkg::screen_y_t [`NUM_OBSTACLES-1:0]   obstacle_y_down
);
    import map_geom_pkg::*;

    localparam screen_x_t HIDE_X = screen_x_t'(`HIDDEN_X);
    localparam screen_y_t HIDE_Y = screen_y_t'(`HIDDEN_Y);

    logic [`NUM_OBSTACLES-1:0] on_screen;

    // Left edge inside the visible columns
    always_comb begin
        for (int i = 0; i < `NUM_OBSTACLES; i++) begin
            on_screen[i] = slot_active[i]
                           && ($signed(slot_x[i]) >= 0)
                           && ($signed(slot_x[i]) < pos_x_t'(`SCREEN_WIDTH));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_OBSTACLES; i++) begin
                obstacle_x_left[i]  <= HIDE_X;
                obstacle_x_right[i] <= HIDE_X;
                obstacle_y_up[i]    <= HIDE_Y;
                obstacle_y_down[i]  <= HIDE_Y;
            end
        end else begin
            for (int i = 0; i < `NUM_OBSTACLES; i++) begin
                if (on_screen[i]) begin
                    obstacle_x_left[i]  <= screen_x_t'(slot_x[i]);
                    obstacle_x_right[i] <= screen_x_t'(slot_x[i]) + screen_x_t'(slot_width[i]);
                    obstacle_y_up[i]    <= slot_y[i];
                    obstacle_y_down[i]  <= slot_y[i] + screen_y_t'(slot_height[i]);
                end else begin
                    obstacle_x_left[i]  <= HIDE_X;
                    obstacle_x_right[i] <= HIDE_X;
                    obstacle_y_up[i]    <= HIDE_Y;
                    obstacle_y_down[i]  <= HIDE_Y;
                end
            end
        end
    end

endmodule

/* verilog/obstacle_field.sv */
`timescale 1ns/1ns

`include "obstacle_map_macros.svh"

module obstacle_field (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  game_ctrl_pkg::game_mode_t                     game_mode,
    input  logic                                          shape_valid,
    input  map_geom_pkg::obs_width_t                      shape_width,
    input  map_geom_pkg::obs_height_t                     shape_height,
    input  map_geom_pkg::screen_y_t                       shape_y,
    input  map_geom_pkg::spawn_gap_t                      shape_gap,
    output logic                                          shape_ready,
    output logic [`NUM_OBSTACLES-1:0]                     slot_active,
    output map_geom_pkg::pos_x_t [`NUM_OBSTACLES-1:0]     slot_x,
    output map_geom_pkg::screen_y_t [`NUM_OBSTACLES-1:0]  slot_y,
    output map_geom_pkg::obs_width_t [`NUM_OBSTACLES-1:0] slot_width,
    output map_geom_pkg::obs_height_t [`NUM_OBSTACLES-1:0] slot_height,
    output game_ctrl_pkg::score_t                         score
);
    import map_geom_pkg::*;
    import game_ctrl_pkg::*;

    localparam int CNT_W = $clog2(`NUM_OBSTACLES + 1);

    // Parking spot and first spawn distance after idle
    localparam pos_x_t PARK_X     = pos_x_t'(`SCREEN_WIDTH + 100);
    localparam pos_x_t START_DIST = pos_x_t'(`SCREEN_WIDTH + `MIN_GAP);
    localparam pos_x_t SPAWN_X    = pos_x_t'(`SCREEN_WIDTH);
    localparam pos_x_t STEP       = pos_x_t'(`SCROLL_SPEED);

    pos_x_t                    spawn_dist;
    pos_x_t                    right_edge;
    logic [`NUM_OBSTACLES-1:0] leaving;
    logic [`NUM_OBSTACLES-1:0] spawn_sel;
    logic                      any_free;
    logic [CNT_W-1:0]          leave_cnt;
    logic [14:0]               score_sum;
    logic                      take_shape;

    // ============================================================
    // Removal detection and free slot search
    // ============================================================
    always_comb begin
        any_free   = 1'b0;
        spawn_sel  = '0;
        leave_cnt  = '0;
        right_edge = '0;
        for (int i = 0; i < `NUM_OBSTACLES; i++) begin
            right_edge = $signed(slot_x[i]) + $signed({5'b0, slot_width[i]});
            leaving[i] = slot_active[i] && (right_edge < pos_x_t'(`DELETE_BOUNDARY));
            if (leaving[i]) begin
                leave_cnt = leave_cnt + 1'b1;
            end
            // Lowest numbered free slot wins
            if (!slot_active[i] && !any_free) begin
                spawn_sel[i] = 1'b1;
                any_free     = 1'b1;
            end
        end
    end

    // Accept a shape only in play, once the gap has scrolled in
    assign shape_ready = (game_mode == MODE_PLAY) && (spawn_dist <= SPAWN_X) && any_free;
    assign take_shape  = shape_valid && shape_ready;
    assign score_sum   = {1'b0, score} + 15'(leave_cnt);

    // ============================================================
    // Slot control, spawn distance and score
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_active <= '0;
            for (int i = 0; i < `NUM_OBSTACLES; i++) begin
                slot_x[i] <= PARK_X;
            end
            spawn_dist <= START_DIST;
            score      <= '0;
        end else begin
            case (game_mode)
                MODE_IDLE: begin
                    slot_active <= '0;
                    for (int i = 0; i < `NUM_OBSTACLES; i++) begin
                        slot_x[i] <= PARK_X;
                    end
                    spawn_dist <= START_DIST;
                    score      <= '0;
                end
                MODE_PLAY: begin
                    for (int i = 0; i < `NUM_OBSTACLES; i++) begin
                        if (take_shape && spawn_sel[i]) begin
                            slot_active[i] <= 1'b1;
                            slot_x[i]      <= SPAWN_X;
                        end else if (slot_active[i]) begin
                            slot_x[i] <= slot_x[i] - STEP;
                            if (leaving[i]) begin
                                slot_active[i] <= 1'b0;
                            end
                        end
                    end
                    if (take_shape) begin
                        spawn_dist <= SPAWN_X + $signed({4'b0, shape_gap});
                    end else begin
                        spawn_dist <= spawn_dist - STEP;
                    end
                    // Removals count in the same cycle they happen
                    if (score_sum > 15'(`SCORE_MAX)) begin
                        score <= score_t'(`SCORE_MAX);
                    end else begin
                        score <= score_sum[13:0];
                    end
                end
                default: begin
                    // Pause, everything holds
                end
            endcase
        end
    end

    // Shape payload of each slot, written at spawn
    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_OBSTACLES; i++) begin
            if (take_shape && spawn_sel[i]) begin
                slot_y[i]      <= shape_y;
                slot_width[i]  <= shape_width;
                slot_height[i] <= shape_height;
            end
        end
    end

endmodule

/* verilog/obstacle_shape_gen.sv */
`timescale 1ns/1ns

`include "obstacle_map_macros.svh"

module obstacle_shape_gen (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      shape_ready,
    output logic                      shape_valid,
    output map_geom_pkg::obs_width_t  shape_width,
    output map_geom_pkg::obs_height_t shape_height,
    output map_geom_pkg::screen_y_t   shape_y,
    output map_geom_pkg::spawn_gap_t  shape_gap
);
    import map_geom_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'h1234_5678;

    logic [31:0] lfsr;
    logic        load_offer;
    obs_width_t  next_width;
    obs_height_t next_height;
    screen_y_t   next_y;
    spawn_gap_t  next_gap;

    // Vertical position with a bias toward the boundary zones
    function automatic screen_y_t pick_y(input logic [31:0] r, input obs_height_t h);
        screen_y_t max_y;
        screen_y_t mid_lo;
        screen_y_t mid_hi;
        screen_y_t y;
        max_y  = screen_y_t'(`LOWER_BOUND - h);
        mid_lo = screen_y_t'(`UPPER_BOUND + `BOUNDARY_ZONE_SIZE);
        mid_hi = max_y - screen_y_t'(`BOUNDARY_ZONE_SIZE);
        if (r[7:0] < 8'(`BOUNDARY_PREFERENCE)) begin
            if (r[8]) begin
                // Upper zone, counted down from the top
                y = screen_y_t'(`UPPER_BOUND)
                    + screen_y_t'((r[23:16] ^ r[15:8]) % `BOUNDARY_ZONE_SIZE);
            end else begin
                // Lower zone, counted up from the lowest legal y
                y = max_y - screen_y_t'((r[15:8] ^ r[31:24]) % `BOUNDARY_ZONE_SIZE);
            end
        end else begin
            // Middle band between the two zones
            y = mid_lo + screen_y_t'((r[31:24] ^ r[15:8]) % (mid_hi - mid_lo));
        end
        if (y > max_y) begin
            y = max_y;
        end
        if (y < screen_y_t'(`UPPER_BOUND)) begin
            y = screen_y_t'(`UPPER_BOUND);
        end
        return y;
    endfunction

    // ============================================================
    // Shape derivation from the current LFSR value
    // ============================================================
    always_comb begin
        next_width  = obs_width_t'(`MIN_OBSTACLE_WIDTH
                      + ((lfsr[7:0] ^ lfsr[15:8])
                         % (`MAX_OBSTACLE_WIDTH - `MIN_OBSTACLE_WIDTH + 1)));
        next_height = obs_height_t'(`MIN_OBSTACLE_HEIGHT
                      + ((lfsr[23:16] ^ lfsr[31:24])
                         % (`MAX_OBSTACLE_HEIGHT - `MIN_OBSTACLE_HEIGHT + 1)));
        next_gap    = spawn_gap_t'(`MIN_GAP
                      + ((lfsr[31:24] ^ lfsr[7:0]) % (`MAX_GAP - `MIN_GAP + 1)));
        next_y      = pick_y(lfsr, next_height);
    end

    // New offer when nothing is held or the held one is taken
    assign load_offer = !shape_valid || shape_ready;

    // ============================================================
    // LFSR and offer valid
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr        <= LFSR_SEED;
            shape_valid <= 1'b0;
        end else begin
            lfsr        <= {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            shape_valid <= 1'b1;
        end
    end

    // Held shape, steady while waiting for the field
    always_ff @(posedge clk) begin
        if (load_offer) begin
            shape_width  <= next_width;
            shape_height <= next_height;
            shape_y      <= next_y;
            shape_gap    <= next_gap;
        end
    end

endmodule

/* verilog/game_ctrl_pkg.sv */
package game_ctrl_pkg;

    // Game mode from the game controller
    // Code 3 is unused and treated as pause
    typedef enum logic [1:0] {
        MODE_IDLE  = 2'd0,
        MODE_PLAY  = 2'd1,
        MODE_PAUSE = 2'd2
    } game_mode_t;

    // Removed obstacle count, saturates at 9999
    typedef logic [13:0] score_t;

endpackage

/* verilog/map_geom_pkg.sv */
package map_geom_pkg;

    // On-screen x, 0 to 639 plus sentinel
    typedef logic [9:0] screen_x_t;

    // Slot x while scrolling, goes negative past the left edge
    typedef logic signed [11:0] pos_x_t;

    // Screen y, play area and sentinel
    typedef logic [8:0] screen_y_t;

    // Obstacle width, 20 to 80
    typedef logic [6:0] obs_width_t;

    // Obstacle height, 20 to 150
    typedef logic [7:0] obs_height_t;

    // Distance to the next spawn, 80 to 180
    typedef logic [7:0] spawn_gap_t;

endpackage

/* verilog/obstacle_map_macros.svh */
`ifndef OBSTACLE_MAP_MACROS_SVH
`define OBSTACLE_MAP_MACROS_SVH

// Slot count and screen geometry
`define NUM_OBSTACLES        10
`define SCREEN_WIDTH         640
`define UPPER_BOUND          20
`define LOWER_BOUND          460

// Pixels moved per frame clock
`define SCROLL_SPEED         4

// Obstacle size ranges
`define MIN_OBSTACLE_WIDTH   20
`define MAX_OBSTACLE_WIDTH   80
`define MIN_OBSTACLE_HEIGHT  20
`define MAX_OBSTACLE_HEIGHT  150

// Spawn distance range
`define MIN_GAP              80
`define MAX_GAP              180

// Boundary zones, preference is out of 256
`define BOUNDARY_ZONE_SIZE   60
`define BOUNDARY_PREFERENCE  102

// Removal threshold and display sentinels
`define DELETE_BOUNDARY      (-100)
`define HIDDEN_X             700
`define HIDDEN_Y             500
`define SCORE_MAX            9999

`endif
